/* Makefile */
# Verilator flow for the vector sequencer testbench

VERILATOR  ?= verilator
TOP        ?= tb_vseq
FILE_LIST  ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= Verification passed
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
+incdir+include
source/vseq_pkg.sv
source/seq_vid_alloc.sv
source/seq_scoreboard.sv
source/seq_hazard_table.sv
source/seq_queue_credit.sv
source/seq_issue_ctrl.sv
source/vseq_top.sv
sim/tb_vseq.sv

/* include/vseq_config.svh */
// Sizes are fixed at elaboration, NR_VINSN must be a power of two and CNT_W must hold every depth
`ifndef VSEQ_CONFIG_SVH
`define VSEQ_CONFIG_SVH

////////////////////////////////////////
// Instruction and register space
////////////////////////////////////////

// Instructions in flight, one ID each
`define VSEQ_NR_VINSN 8

// Architectural vector registers and index width
`define VSEQ_NR_VREGS 32
`define VSEQ_VREG_W 5

// Register that holds the mask for masked instructions
`define VSEQ_VMASK_REG 0

////////////////////////////////////////
// Unit queues
////////////////////////////////////////

// Queue depth per execution unit
`define VSEQ_ALU_DEPTH 4
`define VSEQ_LDU_DEPTH 2
`define VSEQ_STU_DEPTH 2
`define VSEQ_MASKU_DEPTH 1

// Occupancy counter width
`define VSEQ_CNT_W 3

`endif

/* sim/tb_vseq.sv */
// Needs the default sizes of vseq_config.svh, with 8 IDs and queue depths of 4, 2, 2 and 1
`timescale 1ns/1ps

module tb_vseq;
  import vseq_pkg::*;

  // Cycle budget for every wait loop
  localparam int TimeoutCycles = 20;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  seq_req_t   req_i;
  logic       req_valid_i;
  logic       req_ready_o;
  pe_req_t    pe_req_o;
  logic       pe_req_valid_o;
  logic       pe_req_ready_i;
  unit_vids_t unit_done_i;
  vid_mask_t  vinsn_running_o;
  vid_table_t hazard_table_o;
  logic       idle_o;

  integer seed;
  int     mismatches;
  int     timeouts;

  vseq_top i_vseq_top (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .pe_req_o       (pe_req_o),
    .pe_req_valid_o (pe_req_valid_o),
    .pe_req_ready_i (pe_req_ready_i),
    .unit_done_i    (unit_done_i),
    .vinsn_running_o(vinsn_running_o),
    .hazard_table_o (hazard_table_o),
    .idle_o         (idle_o)
  );

  // 100 ns period
  always #50 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic vid_mask_t id_bit(vid_t id);
    vid_mask_t m;
    m = '0;
    m[id] = 1'b1;
    return m;
  endfunction

  function automatic unit_mask_t unit_bit(unit_e u);
    unit_mask_t m;
    m = '0;
    m[u] = 1'b1;
    return m;
  endfunction

  // Decoded request with a random payload
  function automatic seq_req_t make_req(unit_e unit, vreg_t vs1, logic use_vs1, vreg_t vs2,
                                        logic use_vs2, vreg_t vd, logic use_vd, logic vm);
    seq_req_t r;
    r.unit    = unit;
    r.vs1     = vs1;
    r.use_vs1 = use_vs1;
    r.vs2     = vs2;
    r.use_vs2 = use_vs2;
    r.vd      = vd;
    r.use_vd  = use_vd;
    r.vm      = vm;
    r.payload = payload_t'($random(seed));
    return r;
  endfunction

  task automatic check_eq(logic [63:0] actual, logic [63:0] expected, string what);
    assert (actual === expected) else begin
      mismatches++;
      $display("mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, what, actual, expected);
    end
  endtask

  // Tasks below start and end on a falling edge
  task automatic start_req(seq_req_t req);
    req_i       = req;
    req_valid_i = 1'b1;
  endtask

  // Wait for the accept, then capture the PE request one edge later
  task automatic finish_req(output pe_req_t pe);
    int cyc;
    cyc = 0;
    #1;
    while (!req_ready_o && cyc < TimeoutCycles) begin
      @(negedge clk_i);
      #1;
      cyc++;
    end
    if (!req_ready_o) begin
      timeouts++;
      $display("timeout at %0t: the request was never accepted", $time);
      req_valid_i = 1'b0;
      pe          = '0;
      @(negedge clk_i);
    end else begin
      @(negedge clk_i);
      req_valid_i = 1'b0;
      pe          = pe_req_o;
      check_eq(64'(pe_req_valid_o), 64'(1'b1), "pe_req_valid_o after accept");
    end
  endtask

  task automatic send_req(seq_req_t req, output pe_req_t pe);
    start_req(req);
    finish_req(pe);
  endtask

  // Offered request must stay refused
  task automatic expect_stall(int cycles);
    repeat (cycles) begin
      #1;
      check_eq(64'(req_ready_o), 64'(1'b0), "req_ready_o during stall");
      @(negedge clk_i);
    end
  endtask

  // One done pulse per named unit
  task automatic retire(unit_mask_t units, vid_t id);
    for (int u = 0; u < 4; u++) begin
      if (units[u]) begin
        unit_done_i[u][id] = 1'b1;
      end
    end
    @(negedge clk_i);
    unit_done_i = '0;
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic reset_values();
    #1;
    check_eq(64'(idle_o), 64'(1'b1), "idle_o after reset");
    check_eq(64'(pe_req_valid_o), 64'(1'b0), "pe_req_valid_o after reset");
    check_eq(64'(req_ready_o), 64'(1'b1), "req_ready_o after reset");
    check_eq(64'(vinsn_running_o), 64'(0), "vinsn_running_o after reset");
    check_eq(64'(hazard_table_o), 64'(0), "hazard_table_o after reset");
    @(negedge clk_i);
  endtask

  task automatic independent_issue();
    seq_req_t req;
    pe_req_t  pe;
    // Disjoint registers, so no hazards and IDs come out in order
    for (int i = 0; i < 3; i++) begin
      req = make_req(VU_ALU, vreg_t'(8 + i), 1'b1, 5'd0, 1'b0, vreg_t'(16 + i), 1'b1, 1'b1);
      send_req(req, pe);
      check_eq(64'(pe.id), 64'(i), "ID of independent request");
      check_eq(64'(pe.req), 64'(req), "request passed to the PEs");
      check_eq(64'(pe.hazard_vs1 | pe.hazard_vs2 | pe.hazard_vm | pe.hazard_vd), 64'(0),
               "hazards of independent request");
    end
    check_eq(64'(idle_o), 64'(1'b0), "idle_o with work running");
    check_eq(64'(vinsn_running_o),
             64'(id_bit(vid_t'(0)) | id_bit(vid_t'(1)) | id_bit(vid_t'(2))),
             "vinsn_running_o with three running");
    for (int i = 0; i < 3; i++) begin
      retire(unit_bit(VU_ALU), vid_t'(i));
    end
    check_eq(64'(idle_o), 64'(1'b1), "idle_o after retiring all");
    check_eq(64'(vinsn_running_o), 64'(0), "vinsn_running_o after retiring all");
    // Freed IDs are reused from the bottom
    req = make_req(VU_ALU, 5'd9, 1'b1, 5'd0, 1'b0, 5'd17, 1'b1, 1'b1);
    send_req(req, pe);
    check_eq(64'(pe.id), 64'(0), "ID after full retirement");
    retire(unit_bit(VU_ALU), pe.id);
  endtask

  task automatic raw_hazard();
    pe_req_t ld, alu;
    send_req(make_req(VU_LDU, 5'd0, 1'b0, 5'd0, 1'b0, 5'd3, 1'b1, 1'b1), ld);
    send_req(make_req(VU_ALU, 5'd0, 1'b0, 5'd3, 1'b1, 5'd4, 1'b1, 1'b1), alu);
    check_eq(64'(alu.hazard_vs2), 64'(id_bit(ld.id)), "RAW hazard_vs2");
    check_eq(64'(alu.hazard_vs1 | alu.hazard_vm | alu.hazard_vd), 64'(0), "RAW other hazards");
    check_eq(64'(hazard_table_o[alu.id]), 64'(id_bit(ld.id)), "hazard table row on RAW");
    retire(unit_bit(VU_LDU), ld.id);
    check_eq(64'(vinsn_running_o), 64'(id_bit(alu.id)), "vinsn_running_o after writer retires");
    check_eq(64'(hazard_table_o[alu.id]), 64'(0), "hazard table row after writer retires");
    retire(unit_bit(VU_ALU), alu.id);
  endtask

  task automatic war_waw_hazards();
    pe_req_t rd, wr, ww, mw, mk;
    // Reader of v12 that also writes v13
    send_req(make_req(VU_ALU, 5'd12, 1'b1, 5'd0, 1'b0, 5'd13, 1'b1, 1'b1), rd);
    // WAR on v12 blocks every operand read
    send_req(make_req(VU_ALU, 5'd14, 1'b1, 5'd0, 1'b0, 5'd12, 1'b1, 1'b1), wr);
    check_eq(64'(wr.hazard_vs1), 64'(id_bit(rd.id)), "WAR hazard_vs1");
    check_eq(64'(wr.hazard_vs2), 64'(id_bit(rd.id)), "WAR hazard_vs2");
    check_eq(64'(wr.hazard_vm), 64'(id_bit(rd.id)), "WAR hazard_vm");
    check_eq(64'(wr.hazard_vd), 64'(0), "WAR hazard_vd");
    // WAW on v13
    send_req(make_req(VU_ALU, 5'd15, 1'b1, 5'd0, 1'b0, 5'd13, 1'b1, 1'b1), ww);
    check_eq(64'(ww.hazard_vd), 64'(id_bit(rd.id)), "WAW hazard_vd");
    check_eq(64'(ww.hazard_vs1 | ww.hazard_vs2 | ww.hazard_vm), 64'(0), "WAW operand hazards");
    retire(unit_bit(VU_ALU), rd.id);
    retire(unit_bit(VU_ALU), wr.id);
    retire(unit_bit(VU_ALU), ww.id);
    // Writer of the mask register, then a masked reader
    send_req(make_req(VU_ALU, 5'd16, 1'b1, 5'd0, 1'b0, 5'd0, 1'b1, 1'b1), mw);
    send_req(make_req(VU_ALU, 5'd17, 1'b1, 5'd0, 1'b0, 5'd18, 1'b1, 1'b0), mk);
    check_eq(64'(mk.hazard_vm), 64'(id_bit(mw.id)), "masked RAW hazard_vm");
    check_eq(64'(mk.hazard_vs1 | mk.hazard_vd), 64'(0), "masked RAW other hazards");
    retire(unit_bit(VU_ALU), mw.id);
    retire(unit_bit(VU_ALU) | unit_bit(VU_MASKU), mk.id);
  endtask

  task automatic queue_credit_stall();
    pe_req_t s0, s1, s2, m0, m1, wr, ld;
    // Store queue holds two
    send_req(make_req(VU_STU, 5'd20, 1'b1, 5'd0, 1'b0, 5'd0, 1'b0, 1'b1), s0);
    send_req(make_req(VU_STU, 5'd21, 1'b1, 5'd0, 1'b0, 5'd0, 1'b0, 1'b1), s1);
    start_req(make_req(VU_STU, 5'd22, 1'b1, 5'd0, 1'b0, 5'd0, 1'b0, 1'b1));
    expect_stall(3);
    retire(unit_bit(VU_STU), s0.id);
    finish_req(s2);
    check_eq(64'(s2.id), 64'(s0.id), "ID of store issued after a done");
    retire(unit_bit(VU_STU), s1.id);
    retire(unit_bit(VU_STU), s2.id);
    // Mask unit has a single slot
    send_req(make_req(VU_ALU, 5'd4, 1'b1, 5'd0, 1'b0, 5'd5, 1'b1, 1'b0), m0);
    start_req(make_req(VU_ALU, 5'd6, 1'b1, 5'd0, 1'b0, 5'd7, 1'b1, 1'b0));
    expect_stall(3);
    retire(unit_bit(VU_ALU) | unit_bit(VU_MASKU), m0.id);
    finish_req(m1);
    retire(unit_bit(VU_ALU) | unit_bit(VU_MASKU), m1.id);
    // Load with no vector operands and a WAW on v8
    send_req(make_req(VU_ALU, 5'd9, 1'b1, 5'd0, 1'b0, 5'd8, 1'b1, 1'b1), wr);
    start_req(make_req(VU_LDU, 5'd0, 1'b0, 5'd0, 1'b0, 5'd8, 1'b1, 1'b1));
    expect_stall(3);
    retire(unit_bit(VU_ALU), wr.id);
    finish_req(ld);
    check_eq(64'(ld.hazard_vd), 64'(0), "hazard_vd after writer retired");
    retire(unit_bit(VU_LDU), ld.id);
  endtask

  task automatic pe_backpressure();
    pe_req_t pe;
    int      seen;
    pe_req_ready_i = 1'b0;
    send_req(make_req(VU_ALU, 5'd25, 1'b1, 5'd0, 1'b0, 5'd26, 1'b1, 1'b1), pe);
    // Held request must not move
    repeat (3) begin
      #1;
      check_eq(64'(pe_req_valid_o), 64'(1'b1), "pe_req_valid_o while held");
      check_eq(64'(pe_req_o === pe), 64'(1'b1), "pe_req_o stable while held");
      check_eq(64'(req_ready_o), 64'(1'b0), "req_ready_o while held");
      @(negedge clk_i);
    end
    pe_req_ready_i = 1'b1;
    seen = 0;
    repeat (4) begin
      #1;
      if (pe_req_valid_o && pe_req_ready_i) begin
        seen++;
      end
      @(negedge clk_i);
    end
    check_eq(64'(seen), 64'(1), "PE transfers after release");
    retire(unit_bit(VU_ALU), pe.id);
    check_eq(64'(idle_o), 64'(1'b1), "idle_o at end of run");
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    seed           = 11023;
    mismatches     = 0;
    timeouts       = 0;
    rst_ni         = 1'b0;
    req_i          = '0;
    req_valid_i    = 1'b0;
    pe_req_ready_i = 1'b1;
    unit_done_i    = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    reset_values();
    independent_issue();
    raw_hazard();
    war_waw_hazards();
    queue_credit_stall();
    pe_backpressure();

    $display("Summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* source/seq_hazard_table.sv */
// Row N lists the running IDs that instruction N waits on, rows of retired IDs read as zero
`timescale 1ns/1ps

module seq_hazard_table (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 issue_i,
  input  vseq_pkg::vid_t       issue_vid_i,
  input  vseq_pkg::vid_mask_t  hazard_vs1_i,
  input  vseq_pkg::vid_mask_t  hazard_vs2_i,
  input  vseq_pkg::vid_mask_t  hazard_vm_i,
  input  vseq_pkg::vid_mask_t  hazard_vd_i,
  input  vseq_pkg::vid_mask_t  running_next_i,
  output vseq_pkg::vid_table_t table_o
);
  import vseq_pkg::*;

  localparam int unsigned NrVInsn = $bits(vid_mask_t);

  vid_table_t table_d;

  always_comb begin
    table_d = table_o;

    // New row collects every kind of dependency
    if (issue_i) begin
      table_d[issue_vid_i] = hazard_vs1_i | hazard_vs2_i | hazard_vm_i | hazard_vd_i;
    end

    // Retired dependencies vanish from all rows
    for (int i = 0; i < NrVInsn; i++) begin
      if (running_next_i[i]) begin
        table_d[i] &= running_next_i;
      end else begin
        table_d[i] = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      table_o <= '0;
    end else begin
      table_o <= table_d;
    end
  end

endmodule

/* source/seq_issue_ctrl.sv */
// Accepts at most one request per two cycles since a held PE request blocks the dispatcher
`timescale 1ns/1ps

module seq_issue_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  vseq_pkg::seq_req_t   req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  vseq_pkg::vid_mask_t  hazard_vs1_i,
  input  vseq_pkg::vid_mask_t  hazard_vs2_i,
  input  vseq_pkg::vid_mask_t  hazard_vm_i,
  input  vseq_pkg::vid_mask_t  hazard_vd_i,
  input  vseq_pkg::vid_t       next_vid_i,
  input  logic                 full_i,
  input  vseq_pkg::unit_mask_t unit_ready_i,
  output vseq_pkg::pe_req_t    pe_req_o,
  output logic                 pe_req_valid_o,
  input  logic                 pe_req_ready_i,
  output logic                 issue_o,
  output vseq_pkg::vid_t       issue_vid_o,
  output vseq_pkg::unit_mask_t issue_units_o
);
  import vseq_pkg::*;

  issue_state_e state_d, state_q;

  unit_mask_t target_units;
  logic       units_ready;
  logic       no_operands;
  logic       any_hazard;
  logic       stall_no_op;

  ////////////////////////////////////////
  // Stall decision
  ////////////////////////////////////////

  // Own unit, plus the mask unit when masked
  always_comb begin
    target_units              = '0;
    target_units[req_i.unit]  = 1'b1;
    target_units[VU_MASKU]   |= ~req_i.vm;
  end

  // Units not targeted never stall
  assign units_ready = &(unit_ready_i | ~target_units);

  // No operand read means no operand requester can wait on the hazards
  assign no_operands = ~(req_i.use_vs1 | req_i.use_vs2 | ~req_i.vm);
  assign any_hazard  = |{hazard_vs1_i, hazard_vs2_i, hazard_vm_i, hazard_vd_i};
  assign stall_no_op = no_operands & any_hazard;

  assign req_ready_o = (state_q == ST_IDLE) & ~full_i & units_ready & ~stall_no_op;

  // Accept strobe for allocator, scoreboard, table and counters
  assign issue_o       = req_valid_i & req_ready_o;
  assign issue_vid_o   = next_vid_i;
  assign issue_units_o = target_units;

  ////////////////////////////////////////
  // Issue FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (issue_o) begin
          state_d = ST_HOLD;
        end
      end
      ST_HOLD: begin
        // Drop the request once the PEs take it
        if (pe_req_ready_i) begin
          state_d = ST_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request held stable for the whole of ST_HOLD
  always_ff @(posedge clk_i) begin
    if (issue_o) begin
      pe_req_o <= '{
        id        : next_vid_i,
        req       : req_i,
        hazard_vs1: hazard_vs1_i,
        hazard_vs2: hazard_vs2_i,
        hazard_vm : hazard_vm_i,
        hazard_vd : hazard_vd_i
      };
    end
  end

  assign pe_req_valid_o = (state_q == ST_HOLD);

endmodule

/* source/seq_queue_credit.sv */
// Each unit retires at most one instruction per cycle, so a done lowers its count by one
`timescale 1ns/1ps
`include "vseq_config.svh"

module seq_queue_credit (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 issue_i,
  input  vseq_pkg::unit_mask_t issue_units_i,
  input  vseq_pkg::unit_vids_t unit_done_i,
  output vseq_pkg::unit_mask_t unit_ready_o
);
  import vseq_pkg::*;

  localparam int unsigned NrUnits = $bits(unit_mask_t);

  // Queue depths in unit_e order
  localparam cnt_t Depth [NrUnits] = '{
    cnt_t'(`VSEQ_ALU_DEPTH),
    cnt_t'(`VSEQ_LDU_DEPTH),
    cnt_t'(`VSEQ_STU_DEPTH),
    cnt_t'(`VSEQ_MASKU_DEPTH)
  };

  cnt_t       cnt_q [NrUnits];
  unit_mask_t cnt_up, cnt_down;

  for (genvar u = 0; u < NrUnits; u++) begin : gen_unit_cnt
    // Masked instructions count on the mask unit as well
    assign cnt_up[u]   = issue_i & issue_units_i[u];
    assign cnt_down[u] = |unit_done_i[u];

    // Up and down together leave the count as is
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[u] <= '0;
      end else if (cnt_up[u] && !cnt_down[u]) begin
        cnt_q[u] <= cnt_q[u] + cnt_t'(1);
      end else if (cnt_down[u] && !cnt_up[u]) begin
        cnt_q[u] <= cnt_q[u] - cnt_t'(1);
      end
    end

    // Room for one more instruction
    assign unit_ready_o[u] = cnt_q[u] < Depth[u];
  end

endmodule

/* source/seq_scoreboard.sv */
// Only the last reader and last writer of each register are kept, older accesses are assumed ordered
`timescale 1ns/1ps
`include "vseq_config.svh"

module seq_scoreboard (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  vseq_pkg::seq_req_t  req_i,
  input  logic                issue_i,
  input  vseq_pkg::vid_t      issue_vid_i,
  input  vseq_pkg::vid_mask_t running_i,
  output vseq_pkg::vid_mask_t hazard_vs1_o,
  output vseq_pkg::vid_mask_t hazard_vs2_o,
  output vseq_pkg::vid_mask_t hazard_vm_o,
  output vseq_pkg::vid_mask_t hazard_vd_o
);
  import vseq_pkg::*;

  localparam vreg_t VMask = vreg_t'(`VSEQ_VMASK_REG);

  // Last access to one register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

  vreg_access_t [`VSEQ_NR_VREGS-1:0] read_list_d, read_list_q;
  vreg_access_t [`VSEQ_NR_VREGS-1:0] write_list_d, write_list_q;

  // Per-kind hazard contributions of the incoming request
  vid_mask_t raw_vs1, raw_vs2, raw_vm, war_vd, waw_vd;

  // One-hot ID of a live access, zero when unused or retired
  function automatic vid_mask_t live_owner(vreg_access_t entry, vid_mask_t running,
                                           logic used);
    live_owner = '0;
    if (used && entry.valid && running[entry.vid]) begin
      live_owner[entry.vid] = 1'b1;
    end
  endfunction

  ////////////////////////////////////////
  // Hazard detection
  ////////////////////////////////////////

  always_comb begin
    // RAW on sources and on the mask register
    raw_vs1 = live_owner(write_list_q[req_i.vs1], running_i, req_i.use_vs1);
    raw_vs2 = live_owner(write_list_q[req_i.vs2], running_i, req_i.use_vs2);
    raw_vm  = live_owner(write_list_q[VMask], running_i, ~req_i.vm);
    // WAR and WAW on the destination
    war_vd  = live_owner(read_list_q[req_i.vd], running_i, req_i.use_vd);
    waw_vd  = live_owner(write_list_q[req_i.vd], running_i, req_i.use_vd);
  end

  // A pending reader of vd blocks all operand reads of the new instruction
  assign hazard_vs1_o = raw_vs1 | war_vd;
  assign hazard_vs2_o = raw_vs2 | war_vd;
  assign hazard_vm_o  = raw_vm | war_vd;
  assign hazard_vd_o  = waw_vd;

  ////////////////////////////////////////
  // Access lists
  ////////////////////////////////////////

  always_comb begin
    read_list_d  = read_list_q;
    write_list_d = write_list_q;

    // Drop entries of retired IDs
    for (int v = 0; v < `VSEQ_NR_VREGS; v++) begin
      read_list_d[v].valid  = read_list_q[v].valid & running_i[read_list_q[v].vid];
      write_list_d[v].valid = write_list_q[v].valid & running_i[write_list_q[v].vid];
    end

    // Record the accesses of the issued instruction
    if (issue_i) begin
      if (req_i.use_vd) begin
        write_list_d[req_i.vd] = '{vid: issue_vid_i, valid: 1'b1};
      end
      if (req_i.use_vs1) begin
        read_list_d[req_i.vs1] = '{vid: issue_vid_i, valid: 1'b1};
      end
      if (req_i.use_vs2) begin
        read_list_d[req_i.vs2] = '{vid: issue_vid_i, valid: 1'b1};
      end
      // Masked instructions read the mask register
      if (!req_i.vm) begin
        read_list_d[VMask] = '{vid: issue_vid_i, valid: 1'b1};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_list_q  <= '0;
      write_list_q <= '0;
    end else begin
      read_list_q  <= read_list_d;
      write_list_q <= write_list_d;
    end
  end

endmodule

/* source/seq_vid_alloc.sv */
// A unit retires only IDs running on it and the next ID is always the lowest free one
`timescale 1ns/1ps
`include "vseq_config.svh"

module seq_vid_alloc (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 issue_i,
  input  vseq_pkg::vid_t       issue_vid_i,
  input  vseq_pkg::unit_mask_t issue_units_i,
  input  vseq_pkg::unit_vids_t unit_done_i,
  output vseq_pkg::vid_mask_t  running_o,
  output vseq_pkg::vid_mask_t  running_next_o,
  output vseq_pkg::vid_t       next_vid_o,
  output logic                 full_o,
  output logic                 idle_o
);
  import vseq_pkg::*;

  localparam int unsigned NrUnits = $bits(unit_mask_t);

  // Row u holds the IDs still running on unit u
  unit_vids_t unit_running_d, unit_running_q;

  ////////////////////////////////////////
  // Running matrix
  ////////////////////////////////////////

  always_comb begin
    unit_running_d = unit_running_q;
    for (int u = 0; u < NrUnits; u++) begin
      // Retire what the unit reports done
      unit_running_d[u] &= ~unit_done_i[u];
      // Mark the new ID on every targeted unit
      if (issue_i && issue_units_i[u]) begin
        unit_running_d[u][issue_vid_i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      unit_running_q <= '0;
    end else begin
      unit_running_q <= unit_running_d;
    end
  end

  // An ID runs somewhere if any unit row has it
  always_comb begin
    running_o      = '0;
    running_next_o = '0;
    for (int u = 0; u < NrUnits; u++) begin
      running_o      |= unit_running_q[u];
      running_next_o |= unit_running_d[u];
    end
  end

  ////////////////////////////////////////
  // Free ID search
  ////////////////////////////////////////

  // Leading-zero search on the inverted running set
  // Scanning downward lets the lowest free index win
  always_comb begin
    next_vid_o = '0;
    for (int i = `VSEQ_NR_VINSN - 1; i >= 0; i--) begin
      if (!running_o[i]) begin
        next_vid_o = vid_t'(i);
      end
    end
  end

  assign full_o = &running_o;
  assign idle_o = ~|running_o;

endmodule

/* source/vseq_pkg.sv */
// Widths come from vseq_config.svh and unit bit positions follow the order of unit_e
`include "vseq_config.svh"

package vseq_pkg;

  ////////////////////////////////////////
  // Plain vector types
  ////////////////////////////////////////

  // Instruction ID and one bit per instruction in flight
  typedef logic [$clog2(`VSEQ_NR_VINSN)-1:0] vid_t;
  typedef logic [`VSEQ_NR_VINSN-1:0]         vid_mask_t;

  // Vector register index
  typedef logic [`VSEQ_VREG_W-1:0] vreg_t;

  // Queue occupancy
  typedef logic [`VSEQ_CNT_W-1:0] cnt_t;

  // Opaque operation payload for the units
  typedef logic [15:0] payload_t;

  // Execution units
  // Enum value doubles as bit index in unit_mask_t
  typedef enum logic [1:0] {
    VU_ALU   = 2'd0,
    VU_LDU   = 2'd1,
    VU_STU   = 2'd2,
    VU_MASKU = 2'd3
  } unit_e;

  typedef logic [3:0] unit_mask_t;

  // One ID mask per unit, indexed by unit_e
  typedef vid_mask_t [3:0] unit_vids_t;

  // One hazard row per instruction ID
  typedef vid_mask_t [`VSEQ_NR_VINSN-1:0] vid_table_t;

  ////////////////////////////////////////
  // Requests
  ////////////////////////////////////////

  // Decoded instruction from the dispatcher
  typedef struct packed {
    unit_e    unit;
    vreg_t    vs1;
    logic     use_vs1;
    vreg_t    vs2;
    logic     use_vs2;
    vreg_t    vd;
    logic     use_vd;
    logic     vm;       // 1 means unmasked
    payload_t payload;
  } seq_req_t;

  // Issued instruction with its ID and hazards
  typedef struct packed {
    vid_t      id;
    seq_req_t  req;
    vid_mask_t hazard_vs1;
    vid_mask_t hazard_vs2;
    vid_mask_t hazard_vm;
    vid_mask_t hazard_vd;
  } pe_req_t;

  // Issue FSM
  typedef enum logic {
    ST_IDLE,
    ST_HOLD
  } issue_state_e;

endpackage

/* source/vseq_top.sv */
// The dispatcher holds req_i stable while valid and units report done only for their own IDs
`timescale 1ns/1ps

module vseq_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Dispatcher
  input  vseq_pkg::seq_req_t   req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  // Processing elements
  output vseq_pkg::pe_req_t    pe_req_o,
  output logic                 pe_req_valid_o,
  input  logic                 pe_req_ready_i,
  // Retirement, one ID mask per unit
  input  vseq_pkg::unit_vids_t unit_done_i,
  // Status
  output vseq_pkg::vid_mask_t  vinsn_running_o,
  output vseq_pkg::vid_table_t hazard_table_o,
  output logic                 idle_o
);
  import vseq_pkg::*;

  // Issue strobe and its ID and units
  logic       issue;
  vid_t       issue_vid;
  unit_mask_t issue_units;

  // Allocator status
  vid_mask_t  running_next;
  vid_t       next_vid;
  logic       full;

  // Hazards of the incoming request
  vid_mask_t  hazard_vs1, hazard_vs2, hazard_vm, hazard_vd;

  unit_mask_t unit_ready;

  ////////////////////////////////////////
  // ID allocation and running tracking
  ////////////////////////////////////////

  seq_vid_alloc i_vid_alloc (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_i       (issue),
    .issue_vid_i   (issue_vid),
    .issue_units_i (issue_units),
    .unit_done_i   (unit_done_i),
    .running_o     (vinsn_running_o),
    .running_next_o(running_next),
    .next_vid_o    (next_vid),
    .full_o        (full),
    .idle_o        (idle_o)
  );

  // Register access lists
  seq_scoreboard i_scoreboard (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .issue_i     (issue),
    .issue_vid_i (issue_vid),
    .running_i   (vinsn_running_o),
    .hazard_vs1_o(hazard_vs1),
    .hazard_vs2_o(hazard_vs2),
    .hazard_vm_o (hazard_vm),
    .hazard_vd_o (hazard_vd)
  );

  // Global table for the operand requesters
  seq_hazard_table i_hazard_table (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_i       (issue),
    .issue_vid_i   (issue_vid),
    .hazard_vs1_i  (hazard_vs1),
    .hazard_vs2_i  (hazard_vs2),
    .hazard_vm_i   (hazard_vm),
    .hazard_vd_i   (hazard_vd),
    .running_next_i(running_next),
    .table_o       (hazard_table_o)
  );

  // Unit queue occupancy
  seq_queue_credit i_queue_credit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_i      (issue),
    .issue_units_i(issue_units),
    .unit_done_i  (unit_done_i),
    .unit_ready_o (unit_ready)
  );

  ////////////////////////////////////////
  // Issue control
  ////////////////////////////////////////

  seq_issue_ctrl i_issue_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .hazard_vs1_i  (hazard_vs1),
    .hazard_vs2_i  (hazard_vs2),
    .hazard_vm_i   (hazard_vm),
    .hazard_vd_i   (hazard_vd),
    .next_vid_i    (next_vid),
    .full_i        (full),
    .unit_ready_i  (unit_ready),
    .pe_req_o      (pe_req_o),
    .pe_req_valid_o(pe_req_valid_o),
    .pe_req_ready_i(pe_req_ready_i),
    .issue_o       (issue),
    .issue_vid_o   (issue_vid),
    .issue_units_o (issue_units)
  );

endmodule
